// ==== Bender.yml ====
package:
  name: ao_peripheral_subsystem

sources:
  - verilog/ao_periph_pkg.sv
  - verilog/obi_to_reg_bridge.sv
  - verilog/reg_bus_demux.sv
  - verilog/soc_ctrl_regs.sv
  - verilog/ao_timer.sv
  - verilog/power_manager.sv
  - verilog/ao_peripheral_subsystem.sv
  - target: simulation
    files:
      - sim/ao_periph_checker.sv
      - sim/tb_ao_peripheral_subsystem.sv

// ==== sim/ao_periph_checker.sv ====
// ******************************
// Protocol assertions, bound into the OBI bridge
// and into the power manager
// ******************************

`timescale 1ns/100ps
`default_nettype none

module ao_periph_checker
  import ao_periph_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input obi_rsp_t obi_rsp_i,
  input logic     cpu_rst_n_i,
  input logic     power_switch_i
);

  logic assert_failed = 1'b0;

  // Fixed latency from grant to response
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_rsp_i.gnt |-> ##2 obi_rsp_i.rvalid)
    else begin
      $error("rvalid did not follow the grant by two cycles");
      assert_failed = 1'b1;
    end

  // Busy during the register cycle after each grant
  no_gnt_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_rsp_i.gnt |=> !obi_rsp_i.gnt)
    else begin
      $error("gnt was high while the bridge was busy");
      assert_failed = 1'b1;
    end

  // CPU must sit in reset while its power is off
  switch_needs_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    power_switch_i |-> !cpu_rst_n_i)
    else begin
      $error("power switch high while the CPU was out of reset");
      assert_failed = 1'b1;
    end

endmodule : ao_periph_checker

bind obi_to_reg_bridge ao_periph_checker u_bridge_checker (
  .clk_i,
  .reset_i,
  .obi_rsp_i     (obi_rsp_o),
  .cpu_rst_n_i   (1'b1),
  .power_switch_i(1'b0)
);

bind power_manager ao_periph_checker u_power_checker (
  .clk_i,
  .reset_i,
  .obi_rsp_i     ('0),
  .cpu_rst_n_i   (cpu_subsystem_rst_no),
  .power_switch_i(cpu_subsystem_powergate_switch_o)
);

`default_nettype wire

// ==== sim/tb_ao_peripheral_subsystem.sv ====
// ******************************
// Testbench for the always-on peripheral subsystem,
// table of OBI accesses with level checks in between
// ******************************

`timescale 1ns/100ps
`default_nettype none

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  typedef enum {OP_WRITE, OP_READ, OP_WAIT_IRQ} op_e;
  typedef enum {OUT_RST_N, OUT_SWITCH} out_e;

  typedef struct {
    string      name;
    op_e        op;
    word_t      addr;
    word_t      wdata;
    logic [3:0] be;
    word_t      rdata;
    logic       err;
    logic       at_least;
  } entry_t;

  logic     clk = 1'b0;
  logic     reset;
  obi_req_t slave_req;
  obi_rsp_t slave_rsp;
  logic     boot_select;
  logic     execute_from_flash;
  logic     exit_valid;
  word_t    exit_value;
  logic     core_sleep;
  logic     power_switch;
  logic     cpu_rst_n;
  logic     timer_irq;

  entry_t      tbl[$];
  int          next_idx;
  logic [15:0] lfsr_q;
  bit          table_ready = 1'b0;
  word_t       exit_model;
  int          pm_delay = 3;
  int          seg_soc;
  int          seg_timer;
  int          seg_pm;
  int          seg_sleep;
  int          seg_wake;

  ao_peripheral_subsystem u_dut (
    .clk_i                           (clk),
    .reset_i                         (reset),
    .slave_req_i                     (slave_req),
    .slave_rsp_o                     (slave_rsp),
    .boot_select_i                   (boot_select),
    .execute_from_flash_i            (execute_from_flash),
    .exit_valid_o                    (exit_valid),
    .exit_value_o                    (exit_value),
    .core_sleep_i                    (core_sleep),
    .cpu_subsystem_powergate_switch_o(power_switch),
    .cpu_subsystem_rst_no            (cpu_rst_n),
    .timer_irq_o                     (timer_irq)
  );

  always #4 clk = ~clk;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic word_t random_word();
    word_t w;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w[i]   = lfsr_q[0];
    end
    return w;
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, logic [3:0] be);
    word_t res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic word_t reg_addr(periph_idx_e p, logic [3:0] ofs);
    return AO_BASE | (word_t'(p) << 12) | word_t'(ofs);
  endfunction

  function automatic logic level_of(out_e which);
    return (which == OUT_RST_N) ? cpu_rst_n : power_switch;
  endfunction

  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_word_min(string name, word_t min_exp, word_t act);
    if ($isunknown(act) || act < min_exp) begin
      $display("ERROR %s: expected at least %h, actual %h", name, min_exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_state(string name, pm_state_e exp, pm_state_e act);
    if (act !== exp) begin
      $display("ERROR %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
      end_with_failure();
    end
  endtask

  task automatic add_write(string name, word_t addr, word_t wdata,
                           logic [3:0] be = 4'hF, logic err = 1'b0);
    tbl.push_back('{name, OP_WRITE, addr, wdata, be, '0, err, 1'b0});
  endtask

  task automatic add_read(string name, word_t addr, word_t rdata,
                          logic err = 1'b0, logic at_least = 1'b0);
    tbl.push_back('{name, OP_READ, addr, '0, 4'hF, rdata, err, at_least});
  endtask

  task automatic build_table();
    word_t r;
    // Reset values
    add_read("rst exit_valid", reg_addr(PERIPH_SOC_CTRL, SOC_EXIT_VALID_OFS), '0);
    add_read("rst exit_value", reg_addr(PERIPH_SOC_CTRL, SOC_EXIT_VALUE_OFS), '0);
    add_read("rst boot", reg_addr(PERIPH_SOC_CTRL, SOC_BOOT_OFS), 32'h1);
    add_read("rst tmr ctrl", reg_addr(PERIPH_TIMER, TMR_CTRL_OFS), '0);
    add_read("rst tmr prescale", reg_addr(PERIPH_TIMER, TMR_PRESCALE_OFS), '0);
    add_read("rst tmr count", reg_addr(PERIPH_TIMER, TMR_COUNT_OFS), '0);
    add_read("rst tmr compare", reg_addr(PERIPH_TIMER, TMR_COMPARE_OFS), '0);
    add_read("rst pm en", reg_addr(PERIPH_POWER, PM_EN_OFS), '0);
    add_read("rst pm delay", reg_addr(PERIPH_POWER, PM_DELAY_OFS), '0);
    add_read("rst pm status", reg_addr(PERIPH_POWER, PM_STATUS_OFS), word_t'(PM_ACTIVE));
    // Exit value under byte enables
    exit_model = '0;
    for (int i = 0; i < 3; i++) begin
      r = random_word();
      exit_model = merge_bytes(exit_model, r, (i == 0) ? 4'hF : (i == 1) ? 4'h5 : 4'h8);
      add_write($sformatf("exit_value wr %0d", i), reg_addr(PERIPH_SOC_CTRL, SOC_EXIT_VALUE_OFS),
                r, (i == 0) ? 4'hF : (i == 1) ? 4'h5 : 4'h8);
      add_read($sformatf("exit_value rd %0d", i), reg_addr(PERIPH_SOC_CTRL, SOC_EXIT_VALUE_OFS),
               exit_model);
    end
    add_write("exit_valid wr", reg_addr(PERIPH_SOC_CTRL, SOC_EXIT_VALID_OFS), 32'h1, 4'h1);
    add_read("exit_valid rd", reg_addr(PERIPH_SOC_CTRL, SOC_EXIT_VALID_OFS), 32'h1);
    add_write("boot wr ignored", reg_addr(PERIPH_SOC_CTRL, SOC_BOOT_OFS), 32'h3);
    add_read("boot rd", reg_addr(PERIPH_SOC_CTRL, SOC_BOOT_OFS), 32'h1);
    seg_soc = tbl.size();
    // Decode errors, then a normal read
    add_read("slot 3 rd", AO_BASE | 32'h3000, '0, 1'b1);
    add_write("slot 3 wr", AO_BASE | 32'h3004, 32'hFFFF_FFFF, 4'hF, 1'b1);
    add_read("outside window rd", 32'h3000_0004, '0, 1'b1);
    add_read("soc unknown ofs", reg_addr(PERIPH_SOC_CTRL, 4'hC), '0, 1'b1);
    add_read("pm unknown ofs", reg_addr(PERIPH_POWER, 4'hC), '0, 1'b1);
    add_read("read after error", reg_addr(PERIPH_SOC_CTRL, SOC_BOOT_OFS), 32'h1);
    // Timer
    add_write("tmr count", reg_addr(PERIPH_TIMER, TMR_COUNT_OFS), '0);
    add_write("tmr compare", reg_addr(PERIPH_TIMER, TMR_COMPARE_OFS), 32'd20);
    add_write("tmr prescale", reg_addr(PERIPH_TIMER, TMR_PRESCALE_OFS), 32'd1);
    add_write("tmr enable", reg_addr(PERIPH_TIMER, TMR_CTRL_OFS), 32'h1);
    tbl.push_back('{"tmr irq rises", OP_WAIT_IRQ, '0, '0, 4'h0, '0, 1'b0, 1'b0});
    add_read("tmr count after irq", reg_addr(PERIPH_TIMER, TMR_COUNT_OFS), 32'd20, 1'b0, 1'b1);
    add_write("tmr disable", reg_addr(PERIPH_TIMER, TMR_CTRL_OFS), '0);
    seg_timer = tbl.size();
    // Power manager setup
    add_write("pm delay", reg_addr(PERIPH_POWER, PM_DELAY_OFS), word_t'(pm_delay));
    add_write("pm en", reg_addr(PERIPH_POWER, PM_EN_OFS), 32'h1);
    add_read("pm delay rd", reg_addr(PERIPH_POWER, PM_DELAY_OFS), word_t'(pm_delay));
    seg_pm = tbl.size();
    add_read("pm status sleep", reg_addr(PERIPH_POWER, PM_STATUS_OFS), word_t'(PM_SLEEP));
    add_write("tmr compare low", reg_addr(PERIPH_TIMER, TMR_COMPARE_OFS), '0);
    add_write("tmr wake enable", reg_addr(PERIPH_TIMER, TMR_CTRL_OFS), 32'h1);
    tbl.push_back('{"wake irq", OP_WAIT_IRQ, '0, '0, 4'h0, '0, 1'b0, 1'b0});
    seg_sleep = tbl.size();
    add_read("pm status active", reg_addr(PERIPH_POWER, PM_STATUS_OFS), word_t'(PM_ACTIVE));
    add_write("pm en clear", reg_addr(PERIPH_POWER, PM_EN_OFS), '0);
    add_read("pm en rd", reg_addr(PERIPH_POWER, PM_EN_OFS), '0);
    seg_wake = tbl.size();
    add_read("pm status stays", reg_addr(PERIPH_POWER, PM_STATUS_OFS), word_t'(PM_ACTIVE));
  endtask

  task automatic obi_access(input logic we, input word_t addr, input word_t wdata,
                            input logic [3:0] be, output word_t rdata, output logic err);
    bit done;
    slave_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    done = 1'b0;
    for (int n = 0; n < 16 && !done; n++) begin
      @(posedge clk);
      done = slave_rsp.gnt;
    end
    if (!done) begin
      $display("The bridge never granted the request at address %h", addr);
      end_with_failure();
    end
    slave_req.req <= 1'b0;
    done = 1'b0;
    for (int n = 0; n < 16 && !done; n++) begin
      @(posedge clk);
      done = slave_rsp.rvalid;
    end
    if (!done) begin
      $display("No response came back for address %h", addr);
      end_with_failure();
    end
    rdata = slave_rsp.rdata;
    err   = slave_rsp.err;
  endtask

  // Request held high through the busy cycle, second grant lands with rvalid
  task automatic back_to_back_reads(string name, word_t addr, word_t exp);
    slave_req <= '{req: 1'b1, we: 1'b0, be: 4'hF, addr: addr, wdata: '0};
    @(posedge clk);
    check_flag({name, " first gnt"}, 1'b1, slave_rsp.gnt);
    @(posedge clk);
    check_flag({name, " gnt while busy"}, 1'b0, slave_rsp.gnt);
    @(posedge clk);
    check_flag({name, " first rvalid"}, 1'b1, slave_rsp.rvalid);
    check_flag({name, " gnt with rvalid"}, 1'b1, slave_rsp.gnt);
    check_word({name, " first rdata"}, exp, slave_rsp.rdata);
    slave_req.req <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    check_flag({name, " second rvalid"}, 1'b1, slave_rsp.rvalid);
    check_word({name, " second rdata"}, exp, slave_rsp.rdata);
  endtask

  task automatic wait_output(string what, out_e which, logic level);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < 64 && !seen; n++) begin
      @(posedge clk);
      seen = (level_of(which) === level);
    end
    if (!seen) begin
      $display("Timed out while waiting until the %s", what);
      end_with_failure();
    end
  endtask

  task automatic apply_upto(int last);
    entry_t e;
    word_t  rdata;
    logic   err;
    bit     seen;
    while (next_idx < last) begin
      e = tbl[next_idx];
      next_idx++;
      if (e.op == OP_WAIT_IRQ) begin
        seen = 1'b0;
        for (int n = 0; n < 60 && !seen; n++) begin
          @(posedge clk);
          seen = (timer_irq === 1'b1);
        end
        if (!seen) begin
          $display("Timer interrupt did not rise within 60 cycles in %s", e.name);
          end_with_failure();
        end
      end else begin
        obi_access(e.op == OP_WRITE, e.addr, e.wdata, e.be, rdata, err);
        if (e.op == OP_READ && e.addr == reg_addr(PERIPH_POWER, PM_STATUS_OFS)) begin
          check_state(e.name, pm_state_e'(e.rdata[2:0]), pm_state_e'(rdata[2:0]));
        end else if (e.op == OP_READ && e.at_least) begin
          check_word_min(e.name, e.rdata, rdata);
        end else if (e.op == OP_READ) begin
          check_word(e.name, e.rdata, rdata);
        end
        check_flag({e.name, " err"}, e.err, err);
      end
    end
  endtask

  initial begin : watchdog
    wait (table_ready);
    repeat (tbl.size() * 40 + 2000) @(posedge clk);
    $display("Timeout: the test sequence did not finish in time");
    end_with_failure();
  end

  initial begin : main_seq
    reset              = 1'b1;
    slave_req          = '0;
    boot_select        = 1'b1;
    execute_from_flash = 1'b0;
    core_sleep         = 1'b0;
    next_idx           = 0;
    lfsr_q             = 16'd55;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_flag("reset exit_valid_o", 1'b0, exit_valid);
    check_word("reset exit_value_o", '0, exit_value);
    check_flag("reset timer_irq_o", 1'b0, timer_irq);
    check_flag("reset cpu_rst_n", 1'b1, cpu_rst_n);
    check_flag("reset power switch", 1'b0, power_switch);
    check_flag("reset gnt without req", 1'b0, slave_rsp.gnt);
    check_flag("reset rvalid", 1'b0, slave_rsp.rvalid);
    apply_upto(seg_soc);
    check_flag("exit_valid_o set", 1'b1, exit_valid);
    check_word("exit_value_o", exit_model, exit_value);
    back_to_back_reads("back to back boot", reg_addr(PERIPH_SOC_CTRL, SOC_BOOT_OFS), 32'h1);
    apply_upto(seg_timer);
    check_flag("timer irq cleared", 1'b0, timer_irq);
    apply_upto(seg_pm);
    // Sleep entry
    core_sleep <= 1'b1;
    wait_output("cpu reset falls", OUT_RST_N, 1'b0);
    check_flag("switch low while reset asserts", 1'b0, power_switch);
    wait_output("power switch rises", OUT_SWITCH, 1'b1);
    core_sleep <= 1'b0;
    repeat (2 * (pm_delay + 1)) @(posedge clk);
    apply_upto(seg_sleep);
    // Wake on the timer
    wait_output("power switch falls", OUT_SWITCH, 1'b0);
    check_flag("cpu held in reset at switch on", 1'b0, cpu_rst_n);
    wait_output("cpu reset releases", OUT_RST_N, 1'b1);
    apply_upto(seg_wake);
    core_sleep <= 1'b1;
    repeat (4 * (pm_delay + 1)) begin
      @(posedge clk);
      check_flag("no reset with EN clear", 1'b1, cpu_rst_n);
      check_flag("no switch with EN clear", 1'b0, power_switch);
    end
    core_sleep <= 1'b0;
    apply_upto(tbl.size());
    if (u_dut.obi_to_reg_bridge_i.u_bridge_checker.assert_failed ||
        u_dut.power_manager_i.u_power_checker.assert_failed) begin
      $display("A protocol assertion in the bound checker failed");
      end_with_failure();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule : tb_ao_peripheral_subsystem

`default_nettype wire

// ==== src.f ====
verilog/ao_periph_pkg.sv
verilog/obi_to_reg_bridge.sv
verilog/reg_bus_demux.sv
verilog/soc_ctrl_regs.sv
verilog/ao_timer.sv
verilog/power_manager.sv
verilog/ao_peripheral_subsystem.sv
sim/ao_periph_checker.sv
sim/tb_ao_peripheral_subsystem.sv

// ==== verilog/ao_periph_pkg.sv ====
// ******************************
// Bus types, address map and register offsets shared
// by every block of the always-on peripheral subsystem
// ******************************

`default_nettype none

package ao_periph_pkg;

  typedef logic [31:0] word_t;

  typedef struct packed {
    logic       req;
    logic       we;
    logic [3:0] be;
    word_t      addr;
    word_t      wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    word_t rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic       valid;
    logic       write;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    logic  error;
    word_t rdata;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    PERIPH_SOC_CTRL = 2'd0,
    PERIPH_TIMER    = 2'd1,
    PERIPH_POWER    = 2'd2,
    PERIPH_NONE     = 2'd3
  } periph_idx_e;

  typedef enum logic [2:0] {
    PM_ACTIVE,
    PM_RST_ASSERT,
    PM_SWITCH_OFF,
    PM_SLEEP,
    PM_SWITCH_ON,
    PM_RST_RELEASE
  } pm_state_e;

  // Window of 16 KiB, one 4 KiB slot per peripheral
  localparam word_t       AO_BASE        = 32'h2000_0000;
  localparam int unsigned AO_WINDOW_BITS = 14;
  localparam int unsigned NUM_PERIPHS    = 3;

  localparam logic [3:0] SOC_EXIT_VALID_OFS = 4'h0;
  localparam logic [3:0] SOC_EXIT_VALUE_OFS = 4'h4;
  localparam logic [3:0] SOC_BOOT_OFS       = 4'h8;

  localparam logic [3:0] TMR_CTRL_OFS     = 4'h0;
  localparam logic [3:0] TMR_PRESCALE_OFS = 4'h4;
  localparam logic [3:0] TMR_COUNT_OFS    = 4'h8;
  localparam logic [3:0] TMR_COMPARE_OFS  = 4'hC;

  localparam logic [3:0] PM_EN_OFS     = 4'h0;
  localparam logic [3:0] PM_DELAY_OFS  = 4'h4;
  localparam logic [3:0] PM_STATUS_OFS = 4'h8;

  localparam int unsigned PM_DELAY_BITS = 8;

  // Byte-wise merge of new data into a register under the strobes
  function automatic word_t apply_wstrb(word_t old_val, word_t new_val, logic [3:0] strb);
    word_t merged;
    merged = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/ao_peripheral_subsystem.sv ====
// ******************************
// Always-on peripherals behind one OBI slave port
// ******************************

`timescale 1ns/100ps
`default_nettype none

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  obi_req_t slave_req_i,
  output obi_rsp_t slave_rsp_o,
  input  logic     boot_select_i,
  input  logic     execute_from_flash_i,
  output logic     exit_valid_o,
  output word_t    exit_value_o,
  input  logic     core_sleep_i,
  output logic     cpu_subsystem_powergate_switch_o,
  output logic     cpu_subsystem_rst_no,
  output logic     timer_irq_o
);

  reg_req_t                   peripheral_req;
  reg_rsp_t                   peripheral_rsp;
  reg_req_t [NUM_PERIPHS-1:0] peripheral_slv_req;
  reg_rsp_t [NUM_PERIPHS-1:0] peripheral_slv_rsp;
  logic                       timer_irq;

  obi_to_reg_bridge obi_to_reg_bridge_i (
    .clk_i,
    .reset_i,
    .obi_req_i(slave_req_i),
    .obi_rsp_o(slave_rsp_o),
    .reg_req_o(peripheral_req),
    .reg_rsp_i(peripheral_rsp)
  );

  reg_bus_demux reg_bus_demux_i (
    .reg_req_i   (peripheral_req),
    .reg_rsp_o   (peripheral_rsp),
    .periph_req_o(peripheral_slv_req),
    .periph_rsp_i(peripheral_slv_rsp)
  );

  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_i,
    .reset_i,
    .reg_req_i(peripheral_slv_req[PERIPH_SOC_CTRL]),
    .reg_rsp_o(peripheral_slv_rsp[PERIPH_SOC_CTRL]),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  ao_timer ao_timer_i (
    .clk_i,
    .reset_i,
    .reg_req_i  (peripheral_slv_req[PERIPH_TIMER]),
    .reg_rsp_o  (peripheral_slv_rsp[PERIPH_TIMER]),
    .timer_irq_o(timer_irq)
  );

  // Timer interrupt also wakes the CPU
  power_manager power_manager_i (
    .clk_i,
    .reset_i,
    .reg_req_i  (peripheral_slv_req[PERIPH_POWER]),
    .reg_rsp_o  (peripheral_slv_rsp[PERIPH_POWER]),
    .core_sleep_i,
    .timer_irq_i(timer_irq),
    .cpu_subsystem_rst_no,
    .cpu_subsystem_powergate_switch_o
  );

  assign timer_irq_o = timer_irq;

endmodule : ao_peripheral_subsystem

`default_nettype wire

// ==== verilog/ao_timer.sv ====
// ******************************
// Prescaled 32-bit timer, level interrupt
// while enabled and count >= compare
// ******************************

`timescale 1ns/100ps
`default_nettype none

module ao_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     timer_irq_o
);

  logic  wr_en;
  logic  tick;
  logic  enable_q;
  word_t prescale_q;
  word_t presc_cnt_q;
  word_t count_q;
  word_t compare_q;

  assign wr_en = reg_req_i.valid && reg_req_i.write;
  assign tick  = enable_q && (presc_cnt_q >= prescale_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q    <= 1'b0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      count_q     <= '0;
      compare_q   <= '0;
    end else begin
      if (tick) begin
        presc_cnt_q <= '0;
        count_q     <= count_q + 32'd1;
      end else if (enable_q) begin
        presc_cnt_q <= presc_cnt_q + 32'd1;
      end

      // Register writes win over counting
      if (wr_en) begin
        case (reg_req_i.addr[3:2])
          TMR_CTRL_OFS[3:2]: begin
            if (reg_req_i.wstrb[0]) begin
              enable_q <= reg_req_i.wdata[0];
            end
          end
          TMR_PRESCALE_OFS[3:2]: begin
            prescale_q <= apply_wstrb(prescale_q, reg_req_i.wdata, reg_req_i.wstrb);
          end
          TMR_COUNT_OFS[3:2]: begin
            count_q     <= apply_wstrb(count_q, reg_req_i.wdata, reg_req_i.wstrb);
            presc_cnt_q <= '0;
          end
          default: begin
            compare_q <= apply_wstrb(compare_q, reg_req_i.wdata, reg_req_i.wstrb);
          end
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o = '{ready: 1'b1, error: 1'b0, rdata: '0};
    case (reg_req_i.addr[3:2])
      TMR_CTRL_OFS[3:2]:     reg_rsp_o.rdata = {31'b0, enable_q};
      TMR_PRESCALE_OFS[3:2]: reg_rsp_o.rdata = prescale_q;
      TMR_COUNT_OFS[3:2]:    reg_rsp_o.rdata = count_q;
      TMR_COMPARE_OFS[3:2]:  reg_rsp_o.rdata = compare_q;
      default:               reg_rsp_o.error = 1'b1;
    endcase
  end

  assign timer_irq_o = enable_q && (count_q >= compare_q);

endmodule : ao_timer

`default_nettype wire

// ==== verilog/obi_to_reg_bridge.sv ====
// ******************************
// OBI slave to register bus, one access in flight,
// fixed two-cycle latency from grant to rvalid
// ******************************

`timescale 1ns/100ps
`default_nettype none

module obi_to_reg_bridge
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  obi_req_t obi_req_i,
  output obi_rsp_t obi_rsp_o,
  output reg_req_t reg_req_o,
  input  reg_rsp_t reg_rsp_i
);

  logic req_stage_q;
  logic rsp_stage_q;
  logic grant;
  logic reg_done;

  logic       we_q;
  logic [3:0] be_q;
  word_t      addr_q;
  word_t      wdata_q;
  word_t      rdata_q;
  logic       err_q;

  // Idle or retiring the previous access
  assign grant    = obi_req_i.req && !req_stage_q;
  assign reg_done = req_stage_q && reg_rsp_i.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_stage_q <= 1'b0;
      rsp_stage_q <= 1'b0;
    end else begin
      req_stage_q <= grant || (req_stage_q && !reg_rsp_i.ready);
      rsp_stage_q <= reg_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      we_q    <= obi_req_i.we;
      be_q    <= obi_req_i.be;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
    end
    if (reg_done) begin
      rdata_q <= reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  assign reg_req_o = '{
    valid: req_stage_q,
    write: we_q,
    addr:  addr_q,
    wdata: wdata_q,
    wstrb: be_q
  };

  assign obi_rsp_o = '{gnt: grant, rvalid: rsp_stage_q, err: err_q, rdata: rdata_q};

endmodule : obi_to_reg_bridge

`default_nettype wire

// ==== verilog/power_manager.sv ====
// ******************************
// Sleep and wake sequencer for the CPU subsystem,
// each timed step lasts DELAY+1 cycles
// ******************************

`timescale 1ns/100ps
`default_nettype none

module power_manager
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     core_sleep_i,
  input  logic     timer_irq_i,
  output logic     cpu_subsystem_rst_no,
  output logic     cpu_subsystem_powergate_switch_o
);

  logic                     wr_en;
  logic                     en_q;
  logic [PM_DELAY_BITS-1:0] delay_q;
  logic [PM_DELAY_BITS-1:0] step_cnt_q;
  logic                     step_done;
  pm_state_e                state_q;
  pm_state_e                state_d;

  assign wr_en     = reg_req_i.valid && reg_req_i.write;
  assign step_done = step_cnt_q >= delay_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PM_ACTIVE:      if (en_q && core_sleep_i) state_d = PM_RST_ASSERT;
      PM_RST_ASSERT:  if (step_done) state_d = PM_SWITCH_OFF;
      PM_SWITCH_OFF:  if (step_done) state_d = PM_SLEEP;
      PM_SLEEP:       if (timer_irq_i) state_d = PM_SWITCH_ON;
      PM_SWITCH_ON:   if (step_done) state_d = PM_RST_RELEASE;
      PM_RST_RELEASE: if (step_done) state_d = PM_ACTIVE;
      default:        state_d = PM_ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= PM_ACTIVE;
      step_cnt_q <= '0;
      en_q       <= 1'b0;
      delay_q    <= '0;
    end else begin
      state_q <= state_d;
      // Step counter restarts on every state change
      if (state_d != state_q) begin
        step_cnt_q <= '0;
      end else if (state_q != PM_ACTIVE && state_q != PM_SLEEP) begin
        step_cnt_q <= step_cnt_q + 1'b1;
      end
      if (wr_en && reg_req_i.wstrb[0]) begin
        if (reg_req_i.addr[3:2] == PM_EN_OFS[3:2]) begin
          en_q <= reg_req_i.wdata[0];
        end
        if (reg_req_i.addr[3:2] == PM_DELAY_OFS[3:2]) begin
          delay_q <= reg_req_i.wdata[PM_DELAY_BITS-1:0];
        end
      end
    end
  end

  always_comb begin
    reg_rsp_o = '{ready: 1'b1, error: 1'b0, rdata: '0};
    case (reg_req_i.addr[3:2])
      PM_EN_OFS[3:2]:     reg_rsp_o.rdata = {31'b0, en_q};
      PM_DELAY_OFS[3:2]:  reg_rsp_o.rdata = word_t'(delay_q);
      PM_STATUS_OFS[3:2]: reg_rsp_o.rdata = word_t'(state_q);
      default:            reg_rsp_o.error = 1'b1;
    endcase
  end

  // CPU leaves reset only once back in active
  assign cpu_subsystem_rst_no = (state_q == PM_ACTIVE);
  assign cpu_subsystem_powergate_switch_o = (state_q == PM_SWITCH_OFF) || (state_q == PM_SLEEP);

endmodule : power_manager

`default_nettype wire

// ==== verilog/reg_bus_demux.sv ====
// ******************************
// Register bus address decoder and demux,
// unmapped accesses complete with an error
// ******************************

`timescale 1ns/100ps
`default_nettype none

module reg_bus_demux
  import ao_periph_pkg::*;
(
  input  reg_req_t                   reg_req_i,
  output reg_rsp_t                   reg_rsp_o,
  output reg_req_t [NUM_PERIPHS-1:0] periph_req_o,
  input  reg_rsp_t [NUM_PERIPHS-1:0] periph_rsp_i
);

  logic        in_window;
  periph_idx_e sel;

  assign in_window = reg_req_i.addr[31:AO_WINDOW_BITS] == AO_BASE[31:AO_WINDOW_BITS];

  // Top two bits inside the window pick the slot
  always_comb begin
    if (in_window) begin
      sel = periph_idx_e'(reg_req_i.addr[AO_WINDOW_BITS-1 -: 2]);
    end else begin
      sel = PERIPH_NONE;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PERIPHS; i++) begin
      periph_req_o[i]       = reg_req_i;
      periph_req_o[i].valid = reg_req_i.valid && (int'(sel) == i);
    end
  end

  always_comb begin
    if (int'(sel) < NUM_PERIPHS) begin
      reg_rsp_o = periph_rsp_i[sel];
    end else begin
      reg_rsp_o = '{ready: 1'b1, error: 1'b1, rdata: '0};
    end
  end

endmodule : reg_bus_demux

`default_nettype wire

// ==== verilog/soc_ctrl_regs.sv ====
// ******************************
// SoC control registers: exit value and flag
// for the host, boot strap readback
// ******************************

`timescale 1ns/100ps
`default_nettype none

module soc_ctrl_regs
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     boot_select_i,
  input  logic     execute_from_flash_i,
  output logic     exit_valid_o,
  output word_t    exit_value_o
);

  logic  wr_en;
  logic  exit_valid_q;
  word_t exit_value_q;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr[3:2])
        SOC_EXIT_VALID_OFS[3:2]: begin
          if (reg_req_i.wstrb[0]) begin
            exit_valid_q <= reg_req_i.wdata[0];
          end
        end
        SOC_EXIT_VALUE_OFS[3:2]: begin
          exit_value_q <= apply_wstrb(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
        end
        default: ;
      endcase
    end
  end

  // Boot straps are read-only
  always_comb begin
    reg_rsp_o = '{ready: 1'b1, error: 1'b0, rdata: '0};
    case (reg_req_i.addr[3:2])
      SOC_EXIT_VALID_OFS[3:2]: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      SOC_EXIT_VALUE_OFS[3:2]: reg_rsp_o.rdata = exit_value_q;
      SOC_BOOT_OFS[3:2]:       reg_rsp_o.rdata = {30'b0, execute_from_flash_i, boot_select_i};
      default:                 reg_rsp_o.error = 1'b1;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl_regs

`default_nettype wire
